// File: Bender.yml
package:
  name: pipeline16

sources:
  - pipe_pkg.sv
  - ctrl_if.sv
  - pipe_sequencer.sv
  - decode_p0.sv
  - decode_p1.sv
  - control_merge.sv
  - pipeline16.sv
  - target: test
    files:
      - tb_pipeline16_properties.sv
      - tb_pipeline16.sv

// File: control_merge.sv
`timescale 1ns/10ps

module control_merge import pipe_pkg::*; #(
	parameter int NREGS = 8
) (
	input  logic      fetch_active,
	ctrl_if.merge     ctrl_p0,
	ctrl_if.merge     ctrl_p1,
	output alu_op_t   alu_op,
	output reg_mask_t ld_reg_alu_b,
	output reg_mask_t ld_reg_m_b,
	output reg_mask_t ld_reg_p_b,
	output reg_idx_t  alu_a_sel,
	output reg_idx_t  alu_b_sel,
	output logic      m_en_b,
	output reg_idx_t  m_sel,
	output reg_idx_t  maddr_sel,
	output reg_mask_t inc_b,
	output reg_mask_t dec_b,
	output logic      alu_b_from_const_b,
	output logic      mem_oe_b,
	output logic      mem_wr_b,
	output nibble_t   const_nibble
);

	logic             pc_step;    // fetch advances r7
	logic [NREGS-1:0] fetch_inc;

	assign pc_step   = fetch_active & ~(ctrl_p0.hold_pc | ctrl_p1.hold_pc);
	assign fetch_inc = {~pc_step, {(NREGS-1){1'b1}}};  // only r7 bit

	// active low masks combine by AND
	assign ld_reg_alu_b = ctrl_p0.ld_alu_b & ctrl_p1.ld_alu_b;
	assign ld_reg_m_b   = ctrl_p0.ld_mem_b & ctrl_p1.ld_mem_b;
	assign ld_reg_p_b   = ctrl_p0.ld_const_b & ctrl_p1.ld_const_b;
	assign inc_b        = ctrl_p0.inc_b & ctrl_p1.inc_b & fetch_inc;
	assign dec_b        = ctrl_p0.dec_b & ctrl_p1.dec_b;

	// idle stage drives zeros, so OR picks the active one
	assign alu_op             = ctrl_p0.alu_op | ctrl_p1.alu_op;
	assign alu_a_sel          = ctrl_p0.alu_a_sel | ctrl_p1.alu_a_sel;
	assign alu_b_sel          = ctrl_p0.alu_b_sel | ctrl_p1.alu_b_sel;
	assign alu_b_from_const_b = ctrl_p0.b_from_const_b & ctrl_p1.b_from_const_b;
	assign const_nibble       = ctrl_p0.const_nibble | ctrl_p1.const_nibble;

	// bus priority stage 1, stage 0, fetch
	always_comb begin
		if (ctrl_p1.mem_claim) begin
			maddr_sel = ctrl_p1.maddr_sel;
			m_en_b    = ctrl_p1.m_en_b;
			m_sel     = ctrl_p1.m_sel;
			mem_wr_b  = ctrl_p1.mem_wr_b;
		end else if (ctrl_p0.mem_claim) begin
			maddr_sel = ctrl_p0.maddr_sel;
			m_en_b    = ctrl_p0.m_en_b;
			m_sel     = ctrl_p0.m_sel;
			mem_wr_b  = ctrl_p0.mem_wr_b;
		end else begin
			maddr_sel = PC_IDX;  // fetch from r7
			m_en_b    = 1'b1;
			m_sel     = '0;
			mem_wr_b  = 1'b1;
		end
	end

	// a claimed cycle reads unless it writes
	assign mem_oe_b = (ctrl_p0.mem_claim | ctrl_p1.mem_claim) ? ~mem_wr_b : ~fetch_active;

endmodule

// File: ctrl_if.sv
`timescale 1ns/10ps

interface ctrl_if import pipe_pkg::*; ();

	alu_op_t   alu_op;          // alu operation
	reg_idx_t  alu_a_sel;
	reg_idx_t  alu_b_sel;
	logic      b_from_const_b;  // low = alu b from pipeline constant
	reg_mask_t ld_alu_b;        // load from alu output
	reg_mask_t ld_mem_b;        // load from memory
	reg_mask_t ld_const_b;      // load from pout
	reg_mask_t inc_b;
	reg_mask_t dec_b;
	logic      mem_claim;       // stage owns the memory bus
	reg_idx_t  maddr_sel;       // address register when claimed
	logic      m_en_b;          // register drives write data
	reg_idx_t  m_sel;
	logic      mem_wr_b;
	logic      hold_pc;         // suppress fetch increment of r7
	nibble_t   const_nibble;    // low 4 bits of pout

	modport source (output alu_op, alu_a_sel, alu_b_sel, b_from_const_b, ld_alu_b, ld_mem_b,
		ld_const_b, inc_b, dec_b, mem_claim, maddr_sel, m_en_b, m_sel, mem_wr_b, hold_pc,
		const_nibble);

	modport merge (input alu_op, alu_a_sel, alu_b_sel, b_from_const_b, ld_alu_b, ld_mem_b,
		ld_const_b, inc_b, dec_b, mem_claim, maddr_sel, m_en_b, m_sel, mem_wr_b, hold_pc,
		const_nibble);

endinterface

// File: decode_p0.sv
`timescale 1ns/10ps

module decode_p0 import pipe_pkg::*; #(
	parameter int NREGS = 8
) (
	input  word_t    stage0,
	input  logic     c_flag,
	input  logic     z_flag,
	input  logic     s_flag,
	ctrl_if.source   ctrl_p0,
	output logic     flush,
	output logic     stall_req,
	output logic     delay_req,
	output logic     imm_load,
	output imm_hi_t  imm_field
);

	logic [3:0]       cls;     // opcode class
	logic [3:0]       sub;     // bits 11:8
	cond_t            cond;
	logic             taken;
	reg_idx_t         a_fld;   // bits 6:4, dest / store source
	reg_idx_t         b_fld;   // bits 2:0, source / index
	logic [NREGS-1:0] a_low;   // one-hot low at a_fld

	assign cls       = stage0[15:12];
	assign sub       = stage0[11:8];
	assign cond      = cond_t'(stage0[10:8]);
	assign a_fld     = stage0[6:4];
	assign b_fld     = stage0[2:0];
	assign a_low     = ~(NREGS'(1) << a_fld);
	assign imm_field = stage0[11:0];

	always_comb begin
		case (cond)
			COND_Z:      taken = z_flag;
			COND_NZ:     taken = ~z_flag;
			COND_S:      taken = s_flag;
			COND_NS:     taken = ~s_flag;
			COND_C:      taken = c_flag;
			COND_NC:     taken = ~c_flag;
			COND_ALWAYS: taken = 1'b1;
			default:     taken = 1'b0;  // reserved, treated as nop
		endcase
	end

	always_comb begin
		ctrl_p0.alu_op         = ALU_MOVE;
		ctrl_p0.alu_a_sel      = '0;
		ctrl_p0.alu_b_sel      = '0;
		ctrl_p0.b_from_const_b = 1'b1;
		ctrl_p0.ld_alu_b       = MASK_NONE;
		ctrl_p0.ld_mem_b       = MASK_NONE;
		ctrl_p0.ld_const_b     = MASK_NONE;
		ctrl_p0.inc_b          = MASK_NONE;
		ctrl_p0.dec_b          = MASK_NONE;
		ctrl_p0.mem_claim      = 1'b0;
		ctrl_p0.maddr_sel      = '0;
		ctrl_p0.m_en_b         = 1'b1;
		ctrl_p0.m_sel          = '0;
		ctrl_p0.mem_wr_b       = 1'b1;
		ctrl_p0.hold_pc        = 1'b0;
		ctrl_p0.const_nibble   = '0;
		flush                  = 1'b0;
		stall_req              = 1'b0;
		delay_req              = 1'b0;
		imm_load               = 1'b0;

		case (cls)
			CLS_MISC: begin
				if (sub == MISC_INC_MULT) begin
					ctrl_p0.inc_b[NREGS-2:0] = stage0[6:0];  // r7 left to fetch
				end else if (sub == MISC_DEC_MULT) begin
					ctrl_p0.dec_b[NREGS-2:0] = stage0[6:0];
				end
			end
			CLS_IMM: begin
				imm_load = 1'b1;  // upper 12 bits for the next word
			end
			CLS_ALU_RR: begin
				ctrl_p0.alu_op    = {stage0[3], sub};
				ctrl_p0.alu_a_sel = a_fld;
				ctrl_p0.alu_b_sel = b_fld;
				if (!stage0[BIT_NO_STORE])
					ctrl_p0.ld_alu_b = a_low;
			end
			CLS_ALU_RI: begin
				ctrl_p0.alu_op         = alu_op_t'(sub);
				ctrl_p0.alu_a_sel      = a_fld;
				ctrl_p0.b_from_const_b = 1'b0;          // b from pout
				ctrl_p0.const_nibble   = stage0[3:0];
				if (!stage0[BIT_NO_STORE])
					ctrl_p0.ld_alu_b = a_low;           // cmp / test leave it high
			end
			CLS_BRANCH: begin
				if (!stage0[BIT_BR_REG] && taken) begin
					ctrl_p0.hold_pc             = 1'b1;
					ctrl_p0.ld_const_b[PC_IDX]  = 1'b0;  // r7 <= pout
					ctrl_p0.const_nibble        = stage0[3:0];
					flush                       = 1'b1;
					delay_req                   = 1'b1;
				end
			end
			CLS_MEM_RR: begin
				ctrl_p0.mem_claim = 1'b1;
				ctrl_p0.maddr_sel = b_fld;  // index register
				if (stage0[BIT_MEM_STORE]) begin
					ctrl_p0.m_en_b       = 1'b0;
					ctrl_p0.m_sel        = a_fld;
					ctrl_p0.mem_wr_b     = 1'b0;
					ctrl_p0.inc_b[b_fld] = stage0[BIT_POST_INC_B];
					ctrl_p0.dec_b[b_fld] = stage0[BIT_POST_DEC_B];
				end else begin
					stall_req = 1'b1;  // read happens from stage 1
				end
				ctrl_p0.hold_pc        = 1'b1;
				ctrl_p0.dec_b[PC_IDX]  = 1'b0;  // step r7 back for the flushed word
				flush                  = 1'b1;
			end
			default: ;  // 0x6xxx and up decode as nop
		endcase
	end

endmodule

// File: decode_p1.sv
`timescale 1ns/10ps

module decode_p1 import pipe_pkg::*; #(
	parameter int NREGS = 8
) (
	input word_t   stage1,
	ctrl_if.source ctrl_p1
);

	logic             is_load;  // register-index load in its read cycle
	reg_idx_t         idx;
	logic [NREGS-1:0] dst_low;

	assign is_load = (stage1[15:12] == CLS_MEM_RR) && !stage1[BIT_MEM_STORE];
	assign idx     = stage1[2:0];
	assign dst_low = ~(NREGS'(1) << stage1[6:4]);

	always_comb begin
		ctrl_p1.alu_op         = ALU_MOVE;
		ctrl_p1.alu_a_sel      = '0;
		ctrl_p1.alu_b_sel      = '0;
		ctrl_p1.b_from_const_b = 1'b1;
		ctrl_p1.ld_alu_b       = MASK_NONE;
		ctrl_p1.ld_mem_b       = MASK_NONE;
		ctrl_p1.ld_const_b     = MASK_NONE;
		ctrl_p1.inc_b          = MASK_NONE;
		ctrl_p1.dec_b          = MASK_NONE;
		ctrl_p1.mem_claim      = 1'b0;
		ctrl_p1.maddr_sel      = '0;
		ctrl_p1.m_en_b         = 1'b1;
		ctrl_p1.m_sel          = '0;
		ctrl_p1.mem_wr_b       = 1'b1;  // never writes
		ctrl_p1.hold_pc        = 1'b0;
		ctrl_p1.const_nibble   = '0;

		if (is_load) begin
			ctrl_p1.mem_claim    = 1'b1;
			ctrl_p1.maddr_sel    = idx;
			ctrl_p1.ld_mem_b     = dst_low;  // dest <= memory
			ctrl_p1.inc_b[idx]   = stage1[BIT_POST_INC_B];
			ctrl_p1.dec_b[idx]   = stage1[BIT_POST_DEC_B];
		end
	end

endmodule

// File: files.f
pipe_pkg.sv
ctrl_if.sv
pipe_sequencer.sv
decode_p0.sv
decode_p1.sv
control_merge.sv
pipeline16.sv
tb_pipeline16_properties.sv
tb_pipeline16.sv

// File: pipe_pkg.sv
package pipe_pkg;

	typedef logic [15:0] word_t;      // instruction or data word
	typedef logic [2:0]  reg_idx_t;   // r0..r7
	typedef logic [7:0]  reg_mask_t;  // active low, bit n is rn
	typedef logic [4:0]  alu_op_t;
	typedef logic [3:0]  nibble_t;    // low constant bits from the opcode
	typedef logic [11:0] imm_hi_t;    // upper constant bits from an IMM prefix

	// condition field of a direct branch, bits 10:8
	typedef enum logic [2:0] {
		COND_Z      = 3'd0,
		COND_NZ     = 3'd1,
		COND_S      = 3'd2,
		COND_NS     = 3'd3,
		COND_C      = 3'd4,
		COND_NC     = 3'd5,
		COND_ALWAYS = 3'd6,
		COND_RSVD   = 3'd7  // branch link slot, decodes as nop
	} cond_t;

	localparam word_t     NOP_WORD  = 16'h0000;
	localparam reg_idx_t  PC_IDX    = 3'd7;    // program counter
	localparam reg_idx_t  LR_IDX    = 3'd6;    // link register
	localparam reg_mask_t MASK_NONE = 8'hff;   // no register selected
	localparam alu_op_t   ALU_MOVE  = 5'd0;
	localparam imm_hi_t   IMM_CLEAR = 12'h000; // constant upper bits at rest

	// opcode class in bits 15:12
	localparam logic [3:0] CLS_MISC   = 4'h0;
	localparam logic [3:0] CLS_IMM    = 4'h1;
	localparam logic [3:0] CLS_ALU_RR = 4'h2;
	localparam logic [3:0] CLS_ALU_RI = 4'h3;
	localparam logic [3:0] CLS_BRANCH = 4'h4;
	localparam logic [3:0] CLS_MEM_RR = 4'h5;

	// misc sub-opcode in bits 11:8
	localparam logic [3:0] MISC_INC_MULT = 4'h2;
	localparam logic [3:0] MISC_DEC_MULT = 4'h3;

	localparam int BIT_NO_STORE   = 7;   // alu result discarded
	localparam int BIT_MEM_STORE  = 8;   // 0 load, 1 store
	localparam int BIT_POST_INC_B = 9;   // low = post increment index
	localparam int BIT_POST_DEC_B = 10;  // low = post decrement index
	localparam int BIT_BR_REG     = 11;  // register indirect branch

endpackage

// File: pipe_sequencer.sv
`timescale 1ns/10ps

module pipe_sequencer import pipe_pkg::*; (
	input  logic    CLK,
	input  logic    RSTb,
	input  word_t   memory_in,     // word on the bus this cycle
	input  logic    flush,         // drop the fetched word
	input  logic    stall_req,     // load needs a second cycle
	input  logic    delay_req,     // taken branch, one delay slot
	input  logic    imm_load,
	input  imm_hi_t imm_field,
	output word_t   stage0,
	output word_t   stage1,
	output logic    fetch_active,  // low while stage 1 owns the bus
	output imm_hi_t imm_hi
);

	logic    stall_q;     // stall cycle in progress
	logic    delay_q;     // delay slot in progress
	word_t   stage0_next;
	imm_hi_t imm_next;

	// what enters stage 0 at the next edge
	always_comb begin
		if (stall_q || delay_q) begin
			stage0_next = NOP_WORD;  // bubble
		end else if (flush) begin
			stage0_next = NOP_WORD;  // fetched word discarded
		end else begin
			stage0_next = memory_in;
		end
	end

	// IMM prefix lives for exactly one following instruction
	always_comb begin
		if (imm_load) begin
			imm_next = imm_field;
		end else begin
			imm_next = IMM_CLEAR;
		end
	end

	assign fetch_active = ~stall_q;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			stage0  <= NOP_WORD;
			stage1  <= NOP_WORD;
			stall_q <= 1'b0;
			delay_q <= 1'b0;
			imm_hi  <= IMM_CLEAR;
		end else begin
			stage0  <= stage0_next;
			stage1  <= stage0;       // stage 1 trails stage 0 by one cycle
			stall_q <= stall_req;
			delay_q <= delay_req;
			imm_hi  <= imm_next;
		end
	end

	// requests are single cycle strobes, so stall and delay
	// never overlap with a fresh request from a real instruction
	// because stage 0 holds a nop while either is set

endmodule

// File: pipeline16.sv
`timescale 1ns/10ps

module pipeline16 import pipe_pkg::*; #(
	parameter int NREGS = 8
) (
	input  logic      CLK,
	input  logic      RSTb,
	input  word_t     memory_in,           // instruction / data from memory
	input  logic      c_flag,              // alu flags
	input  logic      z_flag,
	input  logic      s_flag,
	output alu_op_t   alu_op,
	output word_t     pout,                // pipeline constant
	output reg_mask_t ld_reg_alu_b,        // load from alu
	output reg_mask_t ld_reg_m_b,          // load from memory
	output reg_mask_t ld_reg_p_b,          // load from pout
	output reg_idx_t  alu_a_sel,
	output reg_idx_t  alu_b_sel,
	output logic      m_en_b,
	output reg_idx_t  m_sel,
	output reg_idx_t  maddr_sel,
	output reg_mask_t inc_b,
	output reg_mask_t dec_b,
	output logic      alu_b_from_const_b,
	output logic      mem_oe_b,
	output logic      mem_wr_b
);

	word_t   stage0;
	word_t   stage1;
	logic    fetch_active;
	imm_hi_t imm_hi;
	imm_hi_t imm_field;
	logic    flush;
	logic    stall_req;
	logic    delay_req;
	logic    imm_load;
	nibble_t const_nibble;

	ctrl_if ctrl_p0 ();  // stage 0 contribution
	ctrl_if ctrl_p1 ();  // stage 1 contribution

	assign pout = {imm_hi, const_nibble};

	pipe_sequencer i_pipe_sequencer (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.memory_in    (memory_in),
		.flush        (flush),
		.stall_req    (stall_req),
		.delay_req    (delay_req),
		.imm_load     (imm_load),
		.imm_field    (imm_field),
		.stage0       (stage0),
		.stage1       (stage1),
		.fetch_active (fetch_active),
		.imm_hi       (imm_hi)
	);

	decode_p0 #(.NREGS(NREGS)) i_decode_p0 (
		.stage0    (stage0),
		.c_flag    (c_flag),
		.z_flag    (z_flag),
		.s_flag    (s_flag),
		.ctrl_p0   (ctrl_p0.source),
		.flush     (flush),
		.stall_req (stall_req),
		.delay_req (delay_req),
		.imm_load  (imm_load),
		.imm_field (imm_field)
	);

	decode_p1 #(.NREGS(NREGS)) i_decode_p1 (
		.stage1  (stage1),
		.ctrl_p1 (ctrl_p1.source)
	);

	control_merge #(.NREGS(NREGS)) i_control_merge (
		.fetch_active       (fetch_active),
		.ctrl_p0            (ctrl_p0.merge),
		.ctrl_p1            (ctrl_p1.merge),
		.alu_op             (alu_op),
		.ld_reg_alu_b       (ld_reg_alu_b),
		.ld_reg_m_b         (ld_reg_m_b),
		.ld_reg_p_b         (ld_reg_p_b),
		.alu_a_sel          (alu_a_sel),
		.alu_b_sel          (alu_b_sel),
		.m_en_b             (m_en_b),
		.m_sel              (m_sel),
		.maddr_sel          (maddr_sel),
		.inc_b              (inc_b),
		.dec_b              (dec_b),
		.alu_b_from_const_b (alu_b_from_const_b),
		.mem_oe_b           (mem_oe_b),
		.mem_wr_b           (mem_wr_b),
		.const_nibble       (const_nibble)
	);

endmodule

// File: tb_pipeline16.sv
`timescale 1ns/10ps

module tb_pipeline16;
	import pipe_pkg::*;

	localparam int CLK_PERIOD     = 100;
	localparam int NUM_ROWS       = 42;                 // fixed rows then random alu rows
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 3 + 20;

	typedef struct packed {
		word_t      word;
		logic [2:0] flags;                            // {c, z, s}
		reg_mask_t  ld_alu, ld_p, ld_m, inc, dec;
		alu_op_t    op;
		reg_idx_t   a_sel, b_sel, maddr, m_sel;
		logic       oe_b, wr_b, m_en_b, b_const_b;
		word_t      pout;
		logic [1:0] fill;                             // nop cycles after decode
	} row_t;

	logic      CLK;
	logic      RSTb;
	word_t     memory_in;
	logic      c_flag;
	logic      z_flag;
	logic      s_flag;
	alu_op_t   alu_op;
	word_t     pout;
	reg_mask_t ld_reg_alu_b;
	reg_mask_t ld_reg_m_b;
	reg_mask_t ld_reg_p_b;
	reg_idx_t  alu_a_sel;
	reg_idx_t  alu_b_sel;
	logic      m_en_b;
	reg_idx_t  m_sel;
	reg_idx_t  maddr_sel;
	reg_mask_t inc_b;
	reg_mask_t dec_b;
	logic      alu_b_from_const_b;
	logic      mem_oe_b;
	logic      mem_wr_b;

	row_t   rows [0:NUM_ROWS-1];
	int     n_rows;
	int     cur_row;   // row under test, -1 after reset
	integer seed;

	pipeline16 #(.NREGS(8)) i_pipeline16 (
		.CLK (CLK), .RSTb (RSTb), .memory_in (memory_in),
		.c_flag (c_flag), .z_flag (z_flag), .s_flag (s_flag),
		.alu_op (alu_op), .pout (pout), .ld_reg_alu_b (ld_reg_alu_b),
		.ld_reg_m_b (ld_reg_m_b), .ld_reg_p_b (ld_reg_p_b),
		.alu_a_sel (alu_a_sel), .alu_b_sel (alu_b_sel), .m_en_b (m_en_b),
		.m_sel (m_sel), .maddr_sel (maddr_sel), .inc_b (inc_b), .dec_b (dec_b),
		.alu_b_from_const_b (alu_b_from_const_b), .mem_oe_b (mem_oe_b), .mem_wr_b (mem_wr_b)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		#(CLK_PERIOD * TIMEOUT_CYCLES);
		$display("timeout: the pipeline test did not reach its end in time");
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	task automatic check(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s is %h, expected %h (row %0d)", $time, name,
				actual, expected, cur_row);
			$display("STATUS: FAIL");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic add_row(input word_t w, input logic [2:0] fl, input reg_mask_t ld_alu, ld_p,
		ld_m, inc, dec, input alu_op_t op, input reg_idx_t a, b, maddr, msel,
		input logic oe, wr, m_en, bc, input word_t po, input logic [1:0] fill);
		rows[n_rows] = {w, fl, ld_alu, ld_p, ld_m, inc, dec, op, a, b, maddr, msel,
			oe, wr, m_en, bc, po, fill};
		n_rows++;
	endtask

	// idle pipeline, only the fetch from r7 with its increment
	function automatic row_t fetch_only();
		row_t r;
		r = {NOP_WORD, 3'b000, MASK_NONE, MASK_NONE, MASK_NONE, 8'h7f, MASK_NONE, ALU_MOVE,
			3'd0, 3'd0, PC_IDX, 3'd0, 1'b0, 1'b1, 1'b1, 1'b1, 16'h0000, 2'd0};
		return r;
	endfunction

	// stall cycle of a load held in stage 1
	function automatic row_t load_read(input word_t w);
		row_t r;
		r = fetch_only();
		r.ld_m[w[6:4]] = 1'b0;   // dest from memory
		r.inc          = MASK_NONE;  // no fetch this cycle
		r.inc[w[2:0]]  = w[9];
		r.dec[w[2:0]]  = w[10];
		r.maddr        = w[2:0];
		return r;
	endfunction

	// alu row expectations from the opcode fields
	function automatic row_t alu_row(input word_t w, input logic [2:0] fl);
		row_t r;
		r = fetch_only();
		r.word  = w;
		r.flags = fl;
		r.a_sel = w[6:4];
		if (w[12]) begin
			r.op        = {1'b0, w[11:8]};   // register immediate
			r.pout      = {12'h000, w[3:0]};
			r.b_const_b = 1'b0;
		end else begin
			r.op    = {w[3], w[11:8]};
			r.b_sel = w[2:0];
		end
		if (!w[7])
			r.ld_alu[w[6:4]] = 1'b0;    // bit 7 set is cmp / test
		return r;
	endfunction

	task automatic build_table();
		logic [15:0] rnd;
		n_rows = 0;
		// word flags ld_alu ld_p ld_m inc dec op a b maddr m_sel oe wr m_en bc pout fill
		add_row('h0000, 'b000, 'hff, 'hff, 'hff, 'h7f, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0000, 0);
		add_row('h0255, 'b000, 'hff, 'hff, 'hff, 'h55, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0000, 0);
		add_row('h032a, 'b000, 'hff, 'hff, 'hff, 'h7f, 'haa, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0000, 0);
		add_row('h2539, 'b000, 'hf7, 'hff, 'hff, 'h7f, 'hff, 'h15, 3, 1, 7, 0, 0, 1, 1, 1, 'h0000, 0);
		add_row('h2ac2, 'b000, 'hff, 'hff, 'hff, 'h7f, 'hff, 'h0a, 4, 2, 7, 0, 0, 1, 1, 1, 'h0000, 0);
		add_row('h2f7e, 'b000, 'h7f, 'hff, 'hff, 'h7f, 'hff, 'h1f, 7, 6, 7, 0, 0, 1, 1, 1, 'h0000, 0);
		add_row('h376b, 'b000, 'hbf, 'hff, 'hff, 'h7f, 'hff, 'h07, 6, 0, 7, 0, 0, 1, 1, 0, 'h000b, 0);
		add_row('h31f0, 'b000, 'hff, 'hff, 'hff, 'h7f, 'hff, 'h01, 7, 0, 7, 0, 0, 1, 1, 0, 'h0000, 0);
		// imm prefix feeds the next word only
		add_row('h1abc, 'b000, 'hff, 'hff, 'hff, 'h7f, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0000, 0);
		add_row('h3215, 'b000, 'hfd, 'hff, 'hff, 'h7f, 'hff, 'h02, 1, 0, 7, 0, 0, 1, 1, 0, 'habc5, 0);
		// each condition taken then not taken
		// not taken rows get a bubble so the next flags arrive on a nop
		add_row('h4003, 'b010, 'hff, 'h7f, 'hff, 'hff, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0003, 2);
		add_row('h4003, 'b000, 'hff, 'hff, 'hff, 'h7f, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0000, 1);
		add_row('h4105, 'b000, 'hff, 'h7f, 'hff, 'hff, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0005, 2);
		add_row('h4105, 'b010, 'hff, 'hff, 'hff, 'h7f, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0000, 1);
		add_row('h4207, 'b001, 'hff, 'h7f, 'hff, 'hff, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0007, 2);
		add_row('h4207, 'b000, 'hff, 'hff, 'hff, 'h7f, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0000, 1);
		add_row('h4309, 'b000, 'hff, 'h7f, 'hff, 'hff, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0009, 2);
		add_row('h4309, 'b001, 'hff, 'hff, 'hff, 'h7f, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0000, 1);
		add_row('h440a, 'b100, 'hff, 'h7f, 'hff, 'hff, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h000a, 2);
		add_row('h440a, 'b011, 'hff, 'hff, 'hff, 'h7f, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0000, 1);
		add_row('h450c, 'b011, 'hff, 'h7f, 'hff, 'hff, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h000c, 2);
		add_row('h450c, 'b100, 'hff, 'hff, 'hff, 'h7f, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0000, 1);
		add_row('h460e, 'b000, 'hff, 'h7f, 'hff, 'hff, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h000e, 2);
		add_row('h4701, 'b111, 'hff, 'hff, 'hff, 'h7f, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0000, 0);
		add_row('h4e01, 'b111, 'hff, 'hff, 'hff, 'h7f, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0000, 0);
		add_row('h1fff, 'b000, 'hff, 'hff, 'hff, 'h7f, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'h0000, 0);
		add_row('h4602, 'b000, 'hff, 'h7f, 'hff, 'hff, 'hff, 0, 0, 0, 7, 0, 0, 1, 1, 1, 'hfff2, 2);
		// stores then loads
		add_row('h5532, 'b000, 'hff, 'hff, 'hff, 'hfb, 'h7f, 0, 0, 0, 2, 3, 1, 0, 0, 1, 'h0000, 1);
		add_row('h5361, 'b000, 'hff, 'hff, 'hff, 'hff, 'h7d, 0, 0, 0, 1, 6, 1, 0, 0, 1, 'h0000, 1);
		add_row('h5453, 'b000, 'hff, 'hff, 'hff, 'hff, 'h7f, 0, 0, 0, 3, 0, 0, 1, 1, 1, 'h0000, 2);
		add_row('h5216, 'b000, 'hff, 'hff, 'hff, 'hff, 'h7f, 0, 0, 0, 6, 0, 0, 1, 1, 1, 'h0000, 2);
		add_row('h5670, 'b000, 'hff, 'hff, 'hff, 'hff, 'h7f, 0, 0, 0, 0, 0, 0, 1, 1, 1, 'h0000, 2);
		while (n_rows < NUM_ROWS) begin
			rnd = $random(seed);
			rows[n_rows] = alu_row({3'b001, rnd[12:0]}, rnd[15:13]);  // class 2 or 3
			n_rows++;
		end
	endtask

	task automatic compare_outputs(input row_t e);
		check("ld_reg_alu_b", ld_reg_alu_b, e.ld_alu);
		check("ld_reg_p_b", ld_reg_p_b, e.ld_p);
		check("ld_reg_m_b", ld_reg_m_b, e.ld_m);
		check("inc_b", inc_b, e.inc);
		check("dec_b", dec_b, e.dec);
		check("alu_op", alu_op, e.op);
		check("alu_a_sel", alu_a_sel, e.a_sel);
		check("alu_b_sel", alu_b_sel, e.b_sel);
		check("maddr_sel", maddr_sel, e.maddr);
		check("m_sel", m_sel, e.m_sel);
		check("mem_oe_b", mem_oe_b, e.oe_b);
		check("mem_wr_b", mem_wr_b, e.wr_b);
		check("m_en_b", m_en_b, e.m_en_b);
		check("alu_b_from_const_b", alu_b_from_const_b, e.b_const_b);
		check("pout", pout, e.pout);
	endtask

	task automatic drive_row(input row_t r);
		memory_in                  = r.word;  // fetched this cycle
		{c_flag, z_flag, s_flag}   = r.flags; // held through the decode cycle
	endtask

	initial begin
		RSTb      = 1'b0;
		memory_in = NOP_WORD;
		c_flag    = 1'b0;
		z_flag    = 1'b0;
		s_flag    = 1'b0;
		seed      = 32'h86ef;
		cur_row   = -1;
		build_table();
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;
		@(negedge CLK);
		compare_outputs(fetch_only());
		drive_row(rows[0]);
		for (int i = 0; i < n_rows; i++) begin
			cur_row = i;
			@(negedge CLK);
			compare_outputs(rows[i]);  // decode cycle
			for (int f = 0; f < rows[i].fill; f++) begin
				memory_in = NOP_WORD;
				@(negedge CLK);
				if (f == 0 && rows[i].word[15:12] == CLS_MEM_RR && !rows[i].word[8])
					compare_outputs(load_read(rows[i].word));
				else
					compare_outputs(fetch_only());  // delay slot or bubble
			end
			if (i + 1 < n_rows)
				drive_row(rows[i + 1]);
			else
				memory_in = NOP_WORD;
		end
		repeat (2) @(negedge CLK);
		if (i_pipeline16.i_properties.bus_fails + i_pipeline16.i_properties.mask_fails +
			i_pipeline16.i_properties.load_fails != 0) begin
			$display("assertion failures were reported during the run");
			$display("STATUS: FAIL");
			$fatal(1, "assertion failures");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

// File: tb_pipeline16_properties.sv
`timescale 1ns/10ps

module tb_pipeline16_properties import pipe_pkg::*; (
	input logic      CLK,
	input logic      RSTb,
	input logic      mem_oe_b,
	input logic      mem_wr_b,
	input reg_idx_t  maddr_sel,
	input reg_mask_t ld_reg_alu_b,
	input word_t     stage1
);

	int   bus_fails  = 0;
	int   mask_fails = 0;
	int   load_fails = 0;
	logic s1_load;   // load in its read cycle

	assign s1_load = (stage1[15:12] == CLS_MEM_RR) && !stage1[BIT_MEM_STORE];

	bus_exclusive: assert property (@(posedge CLK) disable iff (!RSTb)
		!(!mem_oe_b && !mem_wr_b))
	else begin
		bus_fails++;
		$error("memory read and write enabled together");
	end

	// alu result goes to one register at most
	alu_load_onehot: assert property (@(posedge CLK) disable iff (!RSTb)
		$countones(~ld_reg_alu_b) <= 1)
	else begin
		mask_fails++;
		$error("alu result loaded into more than one register");
	end

	// bus returns to the r7 fetch after the read
	load_then_fetch: assert property (@(posedge CLK) disable iff (!RSTb)
		s1_load |=> (!mem_oe_b && maddr_sel == PC_IDX))
	else begin
		load_fails++;
		$error("fetch did not resume after a load");
	end

endmodule

bind pipeline16 tb_pipeline16_properties i_properties (
	.CLK          (CLK),
	.RSTb         (RSTb),
	.mem_oe_b     (mem_oe_b),
	.mem_wr_b     (mem_wr_b),
	.maddr_sel    (maddr_sel),
	.ld_reg_alu_b (ld_reg_alu_b),
	.stage1       (stage1)
);
